//--- design/cnn_accel_cfg.svh
`ifndef CNN_ACCEL_CFG_SVH
`define CNN_ACCEL_CFG_SVH

////////////////////
// Buffer geometry
////////////////////

// Entries per row buffer BRAM
`define BRAM_DEPTH 1024

// Prefetch buffer occupancy width
`define PFB_COUNT_W 10

// Pixel sequence BRAM address width
`define SEQ_ADDR_W 12

////////////////////
// Compute engine array
////////////////////

// Array of AWE blocks
`define NUM_AWE 4

// Engines inside one AWE
`define NUM_CE_PER_AWE 2

// Full length of the engine chain
`define NUM_CE (`NUM_AWE * `NUM_CE_PER_AWE)

////////////////////
// Pixel timing
////////////////////

// Last value of the per-pixel counter, 8 reads per output pixel
`define CYCLE_COUNT 7

// Sequence BRAM read to data valid
`define SEQ_READ_LATENCY 3

`endif

//--- design/cnn_types_pkg.sv
`default_nettype none

package cnn_types_pkg;

    `include "cnn_accel_cfg.svh"

    ////////////////////
    // Geometry widths
    ////////////////////

    // Row or column index, sized to the row buffer depth
    typedef logic [$clog2(`BRAM_DEPTH)-1:0] dim_t;

    // Pixel sequence BRAM address
    typedef logic [`SEQ_ADDR_W-1:0] seq_addr_t;

    // Prefetch buffer entries in one fetched row
    typedef logic [`PFB_COUNT_W-1:0] pfb_count_t;

    ////////////////////
    // Timing and engine widths
    ////////////////////

    // Per-pixel cycle counter, runs 0 to CYCLE_COUNT
    typedef logic [$clog2(`CYCLE_COUNT + 1)-1:0] cyc_t;

    // One strobe bit per compute engine
    typedef logic [`NUM_CE-1:0] ce_vec_t;

endpackage

`default_nettype wire

//--- design/cnn_ctrl_pkg.sv
`default_nettype none

package cnn_ctrl_pkg;

    ////////////////////
    // Job FSM
    ////////////////////

    // Per-job control of the row scan
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_FETCH_ROW,
        SEQ_SCAN,
        SEQ_WAIT_FLUSH,
        SEQ_SEND_COMPLETE
    } seq_state_t;

    ////////////////////
    // Fetch FSM
    ////////////////////

    // One input row from request to drained
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQUEST,
        FETCH_WAIT,
        FETCH_DRAIN
    } fetch_state_t;

endpackage

`default_nettype wire

//--- design/row_fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module row_fetch_ctrl
    import cnn_types_pkg::*;
    import cnn_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       row_fetch_start,
    input  logic       fetch_ack,
    input  logic       fetch_complete,
    input  pfb_count_t pfb_full_count,
    output logic       fetch_request,
    output logic       fetch_in_progress,
    output logic       pfb_rden,
    output logic       row_ready
);

    fetch_state_t state;

    // Entries left to read out of the prefetch buffer
    pfb_count_t   pfb_count;

    ////////////////////
    // Fetch FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= FETCH_IDLE;
            fetch_request     <= 1'b0;
            fetch_in_progress <= 1'b0;
            pfb_rden          <= 1'b0;
            pfb_count         <= '0;
            row_ready         <= 1'b0;
        end else begin
            // Ready is a single pulse
            row_ready <= 1'b0;
            case (state)
                FETCH_IDLE: begin
                    if (row_fetch_start) begin
                        fetch_request <= 1'b1;
                        state         <= FETCH_REQUEST;
                    end
                end
                FETCH_REQUEST: begin
                    // Request held until the memory side acks
                    if (fetch_ack) begin
                        fetch_request     <= 1'b0;
                        fetch_in_progress <= 1'b1;
                        state             <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    // Row landed in the buffer, start the readout next cycle
                    if (fetch_complete) begin
                        fetch_in_progress <= 1'b0;
                        pfb_count         <= pfb_full_count;
                        pfb_rden          <= 1'b1;
                        state             <= FETCH_DRAIN;
                    end
                end
                FETCH_DRAIN: begin
                    pfb_count <= pfb_count - 1'b1;
                    // Last entry being read this cycle
                    if (pfb_count == pfb_count_t'(1)) begin
                        pfb_rden  <= 1'b0;
                        row_ready <= 1'b1;
                        state     <= FETCH_IDLE;
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/scan_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_accel_cfg.svh"

module scan_sequencer
    import cnn_types_pkg::*;
    import cnn_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      job_start,
    input  logic      job_complete_ack,
    input  logic      pipeline_flushed,
    input  dim_t      num_output_cols,
    input  dim_t      num_output_rows,
    input  logic      row_ready,
    output logic      job_accept,
    output logic      job_complete,
    output logic      row_fetch_start,
    output logic      seq_rden,
    output seq_addr_t seq_rdaddr,
    output logic      row_last
);

    seq_state_t state;

    // Job dimensions captured at accept
    dim_t       last_col;
    dim_t       last_row;

    // Scan position
    dim_t       output_col;
    dim_t       output_row;
    cyc_t       cycle_counter;

    logic       pixel_done;
    logic       row_done;

    ////////////////////
    // Scan decode
    ////////////////////

    // Final read of the current pixel
    assign pixel_done = (cycle_counter == cyc_t'(`CYCLE_COUNT));

    // Final read of the current row
    assign row_done   = pixel_done && (output_col == last_col);

    // One sequence read per cycle for the whole row
    assign seq_rden   = (state == SEQ_SCAN);
    assign row_last   = seq_rden && row_done;

    ////////////////////
    // Job FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= SEQ_IDLE;
            job_accept      <= 1'b0;
            job_complete    <= 1'b0;
            row_fetch_start <= 1'b0;
            last_col        <= '0;
            last_row        <= '0;
            output_col      <= '0;
            output_row      <= '0;
            cycle_counter   <= '0;
            seq_rdaddr      <= '0;
        end else begin
            // Strobes default low
            job_accept      <= 1'b0;
            row_fetch_start <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (job_start) begin
                        job_accept      <= 1'b1;
                        last_col        <= num_output_cols;
                        last_row        <= num_output_rows;
                        output_row      <= '0;
                        // First row fetch goes out with the accept
                        row_fetch_start <= 1'b1;
                        state           <= SEQ_FETCH_ROW;
                    end
                end
                SEQ_FETCH_ROW: begin
                    // Buffer drained, row is ready to scan
                    if (row_ready) begin
                        output_col    <= '0;
                        cycle_counter <= '0;
                        seq_rdaddr    <= '0;
                        state         <= SEQ_SCAN;
                    end
                end
                SEQ_SCAN: begin
                    seq_rdaddr <= seq_rdaddr + 1'b1;
                    if (!pixel_done) begin
                        cycle_counter <= cycle_counter + 1'b1;
                    end else begin
                        cycle_counter <= '0;
                        if (!row_done) begin
                            output_col <= output_col + 1'b1;
                        end else if (output_row == last_row) begin
                            // Whole job read out
                            seq_rdaddr <= '0;
                            state      <= SEQ_WAIT_FLUSH;
                        end else begin
                            // Stride one, so one input row per output row
                            seq_rdaddr      <= '0;
                            output_row      <= output_row + 1'b1;
                            row_fetch_start <= 1'b1;
                            state           <= SEQ_FETCH_ROW;
                        end
                    end
                end
                SEQ_WAIT_FLUSH: begin
                    // Engines still busy with the tail of the last row
                    if (pipeline_flushed) begin
                        job_complete <= 1'b1;
                        state        <= SEQ_SEND_COMPLETE;
                    end
                end
                SEQ_SEND_COMPLETE: begin
                    // Complete held through the ack
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= SEQ_IDLE;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/ce_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_accel_cfg.svh"

module ce_dispatch
    import cnn_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    seq_rden,
    input  logic    row_last,
    output ce_vec_t ce_execute,
    output ce_vec_t next_kernel
);

    // Stages ahead of the engine chain, the chain itself adds the last one
    localparam int PRE_DEPTH = `SEQ_READ_LATENCY - 1;

    logic [PRE_DEPTH-1:0] rden_pipe;
    logic [PRE_DEPTH-1:0] last_pipe;

    ////////////////////
    // Read latency match
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rden_pipe <= '0;
            last_pipe <= '0;
        end else begin
            rden_pipe[0] <= seq_rden;
            last_pipe[0] <= row_last;
            for (int k = 1; k < PRE_DEPTH; k++) begin
                rden_pipe[k] <= rden_pipe[k-1];
                last_pipe[k] <= last_pipe[k-1];
            end
        end
    end

    ////////////////////
    // Engine chain
    ////////////////////

    // Engine 0 sees BRAM data, each later engine one cycle behind
    always_ff @(posedge clk) begin
        if (rst) begin
            ce_execute  <= '0;
            next_kernel <= '0;
        end else begin
            ce_execute  <= {ce_execute[`NUM_CE-2:0], rden_pipe[PRE_DEPTH-1]};
            next_kernel <= {next_kernel[`NUM_CE-2:0], last_pipe[PRE_DEPTH-1]};
        end
    end

endmodule

`default_nettype wire

//--- design/quad_bram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module quad_bram_ctrl
    import cnn_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       job_start,
    output logic       job_accept,
    output logic       job_complete,
    input  logic       job_complete_ack,
    input  dim_t       num_output_cols,
    input  dim_t       num_output_rows,
    output logic       fetch_request,
    input  logic       fetch_ack,
    output logic       fetch_in_progress,
    input  logic       fetch_complete,
    input  pfb_count_t pfb_full_count,
    output logic       pfb_rden,
    output logic       seq_rden,
    output seq_addr_t  seq_rdaddr,
    output ce_vec_t    ce_execute,
    output ce_vec_t    next_kernel,
    input  logic       pipeline_flushed
);

    // Sequencer to fetch side
    logic row_fetch_start;
    logic row_ready;

    // Last read of a row, toward the engines
    logic row_last;

    ////////////////////
    // Input side
    ////////////////////

    row_fetch_ctrl u_row_fetch_ctrl (
        .clk               (clk),
        .rst               (rst),
        .row_fetch_start   (row_fetch_start),
        .fetch_ack         (fetch_ack),
        .fetch_complete    (fetch_complete),
        .pfb_full_count    (pfb_full_count),
        .fetch_request     (fetch_request),
        .fetch_in_progress (fetch_in_progress),
        .pfb_rden          (pfb_rden),
        .row_ready         (row_ready)
    );

    ////////////////////
    // Job and scan
    ////////////////////

    scan_sequencer u_scan_sequencer (
        .clk              (clk),
        .rst              (rst),
        .job_start        (job_start),
        .job_complete_ack (job_complete_ack),
        .pipeline_flushed (pipeline_flushed),
        .num_output_cols  (num_output_cols),
        .num_output_rows  (num_output_rows),
        .row_ready        (row_ready),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .row_fetch_start  (row_fetch_start),
        .seq_rden         (seq_rden),
        .seq_rdaddr       (seq_rdaddr),
        .row_last         (row_last)
    );

    ////////////////////
    // Engine strobes
    ////////////////////

    ce_dispatch u_ce_dispatch (
        .clk         (clk),
        .rst         (rst),
        .seq_rden    (seq_rden),
        .row_last    (row_last),
        .ce_execute  (ce_execute),
        .next_kernel (next_kernel)
    );

endmodule

`default_nettype wire

//--- verification/quad_bram_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_accel_cfg.svh"

module quad_bram_ctrl_tb
    import cnn_types_pkg::*;
();

    localparam int NUM_TESTS = 5;

    // Longest fetch handshake with both responder delays at 5
    localparam int FETCH_CYC = 16;

    // One job per entry with its expected counts
    typedef struct {
        dim_t       cols;
        dim_t       rows;
        pfb_count_t pfb;
        dim_t       fetches;
        seq_addr_t  scan_len;
    } test_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       job_start;
    logic       job_accept;
    logic       job_complete;
    logic       job_complete_ack;
    dim_t       num_output_cols;
    dim_t       num_output_rows;
    logic       fetch_request;
    logic       fetch_ack;
    logic       fetch_in_progress;
    logic       fetch_complete;
    pfb_count_t pfb_full_count;
    logic       pfb_rden;
    logic       seq_rden;
    seq_addr_t  seq_rdaddr;
    ce_vec_t    ce_execute;
    ce_vec_t    next_kernel;
    logic       pipeline_flushed;

    test_t tests [NUM_TESTS];
    int    errors;
    int    failed_tests;
    int    cycles;
    int    cycle_limit;

    // Monitor bookkeeping
    logic [15:0] rden_hist;
    int          scan_len;
    int          pfb_len;
    int          scan_runs[$];
    int          pfb_runs[$];
    int          fetch_count;
    int          accept_count;
    int          nk_count;
    logic        req_prev;
    ce_vec_t     exp_ce;
    ce_vec_t     exp_nk;

    always #2 clk = ~clk;

    quad_bram_ctrl dut0 (
        .clk               (clk),
        .rst               (rst),
        .job_start         (job_start),
        .job_accept        (job_accept),
        .job_complete      (job_complete),
        .job_complete_ack  (job_complete_ack),
        .num_output_cols   (num_output_cols),
        .num_output_rows   (num_output_rows),
        .fetch_request     (fetch_request),
        .fetch_ack         (fetch_ack),
        .fetch_in_progress (fetch_in_progress),
        .fetch_complete    (fetch_complete),
        .pfb_full_count    (pfb_full_count),
        .pfb_rden          (pfb_rden),
        .seq_rden          (seq_rden),
        .seq_rdaddr        (seq_rdaddr),
        .ce_execute        (ce_execute),
        .next_kernel       (next_kernel),
        .pipeline_flushed  (pipeline_flushed)
    );

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_dim(input string name, input dim_t got, input dim_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input pfb_count_t got, input pfb_count_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input seq_addr_t got, input seq_addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_ce(input string name, input ce_vec_t got, input ce_vec_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    ////////////////////
    // Monitor
    ////////////////////

    // Outputs sampled on the falling edge
    always @(negedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the jobs did not finish within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end else if (rst) begin
            rden_hist = '0;
            scan_len  = 0;
            pfb_len   = 0;
            req_prev  = 1'b0;
        end else begin
            // Bit k holds seq_rden from k cycles back
            rden_hist = {rden_hist[14:0], seq_rden};
            if (seq_rden) begin
                check_addr("seq_rdaddr", seq_rdaddr, seq_addr_t'(scan_len));
                scan_len++;
            end else if (scan_len != 0) begin
                scan_runs.push_back(scan_len);
                scan_len = 0;
            end
            if (pfb_rden) begin
                pfb_len++;
            end else if (pfb_len != 0) begin
                pfb_runs.push_back(pfb_len);
                pfb_len = 0;
            end
            if (fetch_request && !req_prev) begin
                fetch_count++;
            end
            req_prev = fetch_request;
            if (job_accept) begin
                accept_count++;
            end
            if (next_kernel[0]) begin
                nk_count++;
            end
            // Row last is a read whose next cycle has no read
            for (int i = 0; i < `NUM_CE; i++) begin
                exp_ce[i] = rden_hist[`SEQ_READ_LATENCY + i];
                exp_nk[i] = rden_hist[`SEQ_READ_LATENCY + i]
                            & ~rden_hist[`SEQ_READ_LATENCY - 1 + i];
            end
            check_ce("ce_execute", ce_execute, exp_ce);
            check_ce("next_kernel", next_kernel, exp_nk);
        end
    end

    ////////////////////
    // Stimulus helpers
    ////////////////////

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic int pick_delay();
        return int'($urandom % 6);
    endfunction

    task automatic load_table();
        // cols, rows, pfb entries, fetches, reads per row
        tests[0] = '{10'd0, 10'd0, 10'd1, 10'd1, 12'd8};
        tests[1] = '{10'd3, 10'd2, 10'd4, 10'd3, 12'd32};
        tests[2] = '{10'd1, 10'd4, 10'd2, 10'd5, 12'd16};
        tests[3] = '{10'd7, 10'd1, 10'd9, 10'd2, 12'd64};
        tests[4] = '{10'd2, 10'd3, 10'd3, 10'd4, 12'd24};
    endtask

    function automatic int compute_limit();
        int sum;
        sum = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            sum += int'(tests[t].fetches)
                   * (FETCH_CYC + int'(tests[t].pfb) + 1 + int'(tests[t].scan_len) + 1);
        end
        return 2 * sum + 200;
    endfunction

    // Memory side of one row fetch
    task automatic serve_fetch();
        int d;
        while (!fetch_request) begin
            @(negedge clk);
        end
        check_bit("fetch_in_progress", fetch_in_progress, 1'b0);
        d = pick_delay();
        repeat (d) begin
            @(negedge clk);
            check_bit("fetch_request", fetch_request, 1'b1);
        end
        step();
        check_bit("fetch_request", fetch_request, 1'b1);
        fetch_ack = 1'b1;
        step();
        fetch_ack = 1'b0;
        @(negedge clk);
        check_bit("fetch_request", fetch_request, 1'b0);
        check_bit("fetch_in_progress", fetch_in_progress, 1'b1);
        d = pick_delay();
        repeat (d) begin
            @(negedge clk);
            check_bit("fetch_in_progress", fetch_in_progress, 1'b1);
        end
        step();
        check_bit("fetch_in_progress", fetch_in_progress, 1'b1);
        fetch_complete = 1'b1;
        step();
        fetch_complete = 1'b0;
        // Readout starts the cycle after completion
        @(negedge clk);
        check_bit("fetch_in_progress", fetch_in_progress, 1'b0);
        check_bit("pfb_rden", pfb_rden, 1'b1);
    endtask

    ////////////////////
    // One job
    ////////////////////

    task automatic run_job(input int t);
        int d;
        int err_before;
        err_before = errors;
        step();
        scan_runs.delete();
        pfb_runs.delete();
        fetch_count     = 0;
        accept_count    = 0;
        nk_count        = 0;
        num_output_cols = tests[t].cols;
        num_output_rows = tests[t].rows;
        pfb_full_count  = tests[t].pfb;
        job_start       = 1'b1;
        @(negedge clk);
        check_bit("job_accept", job_accept, 1'b0);
        @(negedge clk);
        check_bit("job_accept", job_accept, 1'b1);
        step();
        job_start = 1'b0;
        for (int r = 0; r < int'(tests[t].fetches); r++) begin
            serve_fetch();
        end
        while (scan_runs.size() < int'(tests[t].fetches)) begin
            @(posedge clk);
        end
        // Let the strobes leave the engine chain
        repeat (`SEQ_READ_LATENCY + `NUM_CE + 2) @(posedge clk);
        d = pick_delay();
        repeat (d) begin
            @(negedge clk);
            check_bit("job_complete", job_complete, 1'b0);
        end
        step();
        check_bit("job_complete", job_complete, 1'b0);
        pipeline_flushed = 1'b1;
        step();
        pipeline_flushed = 1'b0;
        @(negedge clk);
        check_bit("job_complete", job_complete, 1'b1);
        d = pick_delay();
        repeat (d) begin
            @(negedge clk);
            check_bit("job_complete", job_complete, 1'b1);
        end
        step();
        check_bit("job_complete", job_complete, 1'b1);
        job_complete_ack = 1'b1;
        step();
        job_complete_ack = 1'b0;
        @(negedge clk);
        check_bit("job_complete", job_complete, 1'b0);
        check_bit("seq_rden", seq_rden, 1'b0);
        step();
        // Totals for the job
        check_dim("job_accept pulses", dim_t'(accept_count), dim_t'(1));
        check_dim("fetch_request raises", dim_t'(fetch_count), tests[t].fetches);
        check_dim("next_kernel[0] pulses", dim_t'(nk_count), tests[t].fetches);
        check_dim("scan rows", dim_t'(scan_runs.size()), tests[t].fetches);
        check_dim("pfb_rden runs", dim_t'(pfb_runs.size()), tests[t].fetches);
        foreach (scan_runs[k]) begin
            check_addr("seq_rden run length", seq_addr_t'(scan_runs[k]), tests[t].scan_len);
        end
        foreach (pfb_runs[k]) begin
            check_count("pfb_rden run length", pfb_count_t'(pfb_runs[k]), tests[t].pfb);
        end
        if (errors != err_before) begin
            failed_tests++;
        end
        $display("Test %0d cols %0d rows %0d pfb %0d: %0d errors", t, tests[t].cols,
                 tests[t].rows, tests[t].pfb, errors - err_before);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        void'($urandom(32'hc868edd9));
        rst              = 1'b1;
        job_start        = 1'b0;
        job_complete_ack = 1'b0;
        num_output_cols  = '0;
        num_output_rows  = '0;
        fetch_ack        = 1'b0;
        fetch_complete   = 1'b0;
        pfb_full_count   = '0;
        pipeline_flushed = 1'b0;
        errors           = 0;
        failed_tests     = 0;
        cycles           = 0;
        load_table();
        cycle_limit = compute_limit();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle outputs straight out of reset
        @(negedge clk);
        check_bit("job_accept", job_accept, 1'b0);
        check_bit("job_complete", job_complete, 1'b0);
        check_bit("fetch_request", fetch_request, 1'b0);
        check_bit("fetch_in_progress", fetch_in_progress, 1'b0);
        check_bit("pfb_rden", pfb_rden, 1'b0);
        check_bit("seq_rden", seq_rden, 1'b0);
        check_addr("seq_rdaddr", seq_rdaddr, '0);
        check_ce("ce_execute", ce_execute, '0);
        check_ce("next_kernel", next_kernel, '0);
        $display("Reset check: %0d errors", errors);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_job(t);
        end
        $display("Tests %0d, failing %0d, errors %0d", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/cnn_types_pkg.sv
design/cnn_ctrl_pkg.sv
design/row_fetch_ctrl.sv
design/scan_sequencer.sv
design/ce_dispatch.sv
design/quad_bram_ctrl.sv
verification/quad_bram_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only on the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module quad_bram_ctrl_tb \
    -f vlog.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null &&
echo "run_sim: passed" ||
{ echo "run_sim: failed"; exit 1; }
